/* verilog.f */
+incdir+rtl
rtl/riscv_pkg.sv
rtl/dataflow_ctrl_if.sv
rtl/imm_gen.sv
rtl/alu.sv
rtl/regfile.sv
rtl/dataflow.sv
rtl/control_unit.sv
rtl/riscv_core.sv
testbench/clock_gen.sv
testbench/tb_riscv_core.sv

/* testbench/tb_riscv_core.sv */
// ====================
// RV64 core testbench
// Runs hand-encoded programs, checks stored results
// ====================

`timescale 1ns/100ps
`default_nettype none

module tb_riscv_core;

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DELAY  = 10;
  localparam int RESET_CYCLES = 10;
  localparam int MEM_WORDS    = 256;
  localparam int DATA_BASE    = 'h400;
  localparam int RESULT_BASE  = 'h500;
  // Executed instructions per test at most, each at most 5 cycles
  localparam int INSN_BUDGET  = 100;
  localparam int TEST_COUNT   = 5;
  localparam longint WATCHDOG_NS =
    TEST_COUNT * (INSN_BUDGET * 5 + 2 * RESET_CYCLES) * CLK_PERIOD + 10000;

  localparam logic [6:0] OP_REG = 7'b0110011;
  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] OP_32  = 7'b0111011;

  logic        clk, por_n, core_rst_n, rst_n;
  logic [63:0] mem_rdata, mem_addr, mem_wdata;
  logic        mem_we, halted;
  logic [63:0] mem [MEM_WORDS];
  logic [31:0] prog [$];
  logic [31:0] rng_state;
  string       test_name;
  int          test_errors, tests_passed, tests_failed;

  clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES), .DRIVE_DELAY(DRIVE_DELAY))
    u_clock_gen (.clk_o(clk), .rst_n_o(por_n));

  assign rst_n = por_n & core_rst_n;

  riscv_core dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .mem_rdata_i (mem_rdata),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_we_o    (mem_we),
    .halted_o    (halted)
  );

  // Doubleword memory, combinational read
  assign mem_rdata = mem[mem_addr[10:3]];

  always @(posedge clk) begin
    if (mem_we) mem[mem_addr[10:3]] <= mem_wdata;
  end

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, rs2,
                                         input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] addi(input logic [4:0] rd, rs1, input int imm);
    return {imm[11:0], rs1, 3'b000, rd, OP_IMM};
  endfunction

  function automatic logic [31:0] load(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                       input int imm);
    return {imm[11:0], rs1, f3, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] sd(input logic [4:0] rs2, rs1, input int imm);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                         input int off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal(input logic [4:0] rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] lui(input logic [4:0] rd, input int imm);
    return {imm[19:0], rd, 7'b0110111};
  endfunction

  // Sign-extension rules of RV64
  function automatic logic [63:0] sext12(input int imm);
    return {{52{imm[11]}}, imm[11:0]};
  endfunction

  function automatic logic [63:0] sext32(input logic [31:0] w);
    return {{32{w[31]}}, w};
  endfunction

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic logic [63:0] fill_value(input int idx);
    return {32'hbad0_f111, idx[31:0]};
  endfunction

  function automatic void emit(input logic [31:0] insn);
    prog.push_back(insn);
  endfunction

  function automatic void put_data(input int k, input logic [63:0] value);
    mem[DATA_BASE / 8 + k] = value;
  endfunction

  // Hold the core in reset, clear memory and start a new program
  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
    prog.delete();
    @(posedge clk);
    #DRIVE_DELAY core_rst_n = 1'b0;
    @(posedge clk);
    #DRIVE_DELAY;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = fill_value(i);
    emit(addi(1, 0, DATA_BASE));
    emit(addi(2, 0, RESULT_BASE));
  endtask

  task automatic run_program();
    int cycles;
    emit(32'h0010_0073);
    for (int i = 0; i < prog.size(); i++) begin
      if (i % 2) mem[i / 2][63:32] = prog[i];
      else mem[i / 2][31:0] = prog[i];
    end
    repeat (RESET_CYCLES - 1) @(posedge clk);
    #DRIVE_DELAY core_rst_n = 1'b1;
    cycles = 0;
    while (halted !== 1'b1 && cycles < INSN_BUDGET * 5) begin
      @(posedge clk);
      #DRIVE_DELAY cycles++;
    end
    assert (halted === 1'b1) else begin
      $display("%s: core did not halt within %0d cycles", test_name, cycles);
      test_errors++;
    end
  endtask

  task automatic check_word(input logic [63:0] addr, input logic [63:0] expected,
                            input string what);
    assert (mem[addr[10:3]] === expected) else begin
      $display("FAILED at %0t: %s, %s at 0x%0h is %h, expected %h", $time, test_name,
               what, addr, mem[addr[10:3]], expected);
      test_errors++;
    end
  endtask

  task automatic end_test();
    if (test_errors == 0) begin
      tests_passed++;
      $display("%s: passed", test_name);
    end else begin
      tests_failed++;
      $display("%s: %0d check(s) failed", test_name, test_errors);
    end
  endtask

  task automatic arith_logic_test();
    logic [63:0] a, b;
    logic [63:0] expect_q [8];
    logic [2:0]  f3 [7] = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100, 3'b010, 3'b011};
    logic [6:0]  f7 [7] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00};
    begin_test("arith_logic");
    a = -64'd37;
    b = 64'd1234567890123;
    put_data(0, a);
    put_data(1, b);
    emit(load(3'b011, 3, 1, 0));
    emit(load(3'b011, 4, 1, 8));
    // ADD, SUB, AND, OR, XOR, SLT, SLTU
    for (int k = 0; k < 7; k++) begin
      emit(r_type(f7[k], f3[k], 5, 3, 4, OP_REG));
      emit(sd(5, 2, 8 * k));
    end
    emit(addi(5, 3, -100));
    emit(sd(5, 2, 56));
    run_program();
    expect_q = '{a + b, a - b, a & b, a | b, a ^ b,
                 {63'd0, $signed(a) < $signed(b)}, {63'd0, a < b}, a + sext12(-100)};
    for (int k = 0; k < 8; k++) check_word(RESULT_BASE + 8 * k, expect_q[k], "ALU result");
    end_test();
  endtask

  task automatic word_load_test();
    logic [63:0] a, b, c;
    begin_test("word_mode_loads");
    a = 64'h0000_0000_7fff_fff0;
    b = 64'h0000_0000_0000_0020;
    c = 64'h1234_5678_8765_4321;
    put_data(0, a);
    put_data(1, b);
    put_data(2, c);
    emit(load(3'b011, 3, 1, 0));
    emit(load(3'b011, 4, 1, 8));
    emit(r_type(7'h00, 3'b000, 5, 3, 4, OP_32));
    emit(sd(5, 2, 0));
    emit(load(3'b010, 6, 1, 16));
    emit(sd(6, 2, 8));
    emit(load(3'b011, 7, 1, 16));
    emit(sd(7, 2, 16));
    emit(load(3'b010, 8, 1, 20));
    emit(sd(8, 2, 24));
    run_program();
    check_word(RESULT_BASE, sext32(a[31:0] + b[31:0]), "ADDW overflow");
    check_word(RESULT_BASE + 8, sext32(c[31:0]), "LW negative word");
    check_word(RESULT_BASE + 16, c, "LD same address");
    check_word(RESULT_BASE + 24, sext32(c[63:32]), "LW upper word");
    end_test();
  endtask

  task automatic control_flow_test();
    int          loop_start;
    int          jal_pc;
    logic [63:0] sum;
    begin_test("control_flow");
    emit(addi(3, 0, 0));
    emit(addi(4, 0, 1));
    emit(addi(5, 0, 11));
    loop_start = prog.size();
    emit(r_type(7'h00, 3'b000, 3, 3, 4, OP_REG));
    emit(addi(4, 4, 1));
    emit(branch(3'b001, 4, 5, 4 * (loop_start - prog.size())));
    emit(sd(3, 2, 0));
    jal_pc = 4 * prog.size();
    emit(jal(6, 8));
    emit(sd(5, 2, 8));
    emit(sd(6, 2, 16));
    // Write to x0 must be dropped
    emit(addi(0, 0, 5));
    emit(sd(0, 2, 24));
    emit(branch(3'b000, 3, 3, 8));
    emit(sd(5, 2, 32));
    emit(branch(3'b000, 3, 4, 8));
    emit(sd(4, 2, 40));
    run_program();
    sum = 0;
    for (int i = 1; i <= 10; i++) sum += i;
    check_word(RESULT_BASE, sum, "loop sum");
    check_word(RESULT_BASE + 8, fill_value((RESULT_BASE + 8) / 8), "store skipped by JAL");
    check_word(RESULT_BASE + 16, jal_pc + 4, "JAL link");
    check_word(RESULT_BASE + 24, 64'd0, "x0 after write");
    check_word(RESULT_BASE + 32, fill_value((RESULT_BASE + 32) / 8), "store skipped by BEQ");
    check_word(RESULT_BASE + 40, 64'd11, "BEQ not taken");
    end_test();
  endtask

  task automatic lui_imm_test();
    logic [63:0] d, x4;
    begin_test("lui_immediates");
    d = 64'hfedc_ba98_7654_3210;
    put_data(0, d);
    emit(lui(3, 'h80000));
    emit(sd(3, 2, 0));
    emit(lui(4, 'h12345));
    emit(addi(4, 4, -1));
    emit(sd(4, 2, 8));
    emit(addi(5, 2, 64));
    emit(sd(4, 5, -16));
    emit(addi(7, 1, 16));
    emit(load(3'b011, 6, 7, -16));
    emit(sd(6, 2, 24));
    emit(addi(8, 0, -2048));
    emit(sd(8, 2, 32));
    run_program();
    // LUI places the 20 bits above 12 zeros and sign-extends bit 31
    x4 = {32'd0, 20'h12345, 12'd0} + sext12(-1);
    check_word(RESULT_BASE, {{32{1'b1}}, 20'h80000, 12'd0}, "LUI top bit");
    check_word(RESULT_BASE + 8, x4, "LUI plus ADDI");
    check_word(RESULT_BASE + 64 + sext12(-16), x4, "negative S offset");
    check_word(RESULT_BASE + 24, d, "negative I offset load");
    check_word(RESULT_BASE + 32, sext12(-2048), "ADDI minimum immediate");
    end_test();
  endtask

  task automatic random_operand_test();
    logic [63:0] xs [8];
    logic [63:0] ys [8];
    begin_test("random_operands");
    for (int k = 0; k < 8; k++) begin
      xs[k] = {lcg_next(), lcg_next()};
      ys[k] = {lcg_next(), lcg_next()};
      put_data(2 * k, xs[k]);
      put_data(2 * k + 1, ys[k]);
      emit(load(3'b011, 3, 1, 16 * k));
      emit(load(3'b011, 4, 1, 16 * k + 8));
      emit(r_type(7'h00, 3'b000, 5, 3, 4, OP_REG));
      emit(sd(5, 2, 24 * k));
      emit(r_type(7'h20, 3'b000, 6, 3, 4, OP_REG));
      emit(sd(6, 2, 24 * k + 8));
      emit(r_type(7'h00, 3'b100, 7, 3, 4, OP_REG));
      emit(sd(7, 2, 24 * k + 16));
    end
    run_program();
    for (int k = 0; k < 8; k++) begin
      check_word(RESULT_BASE + 24 * k, xs[k] + ys[k], "random ADD");
      check_word(RESULT_BASE + 24 * k + 8, xs[k] - ys[k], "random SUB");
      check_word(RESULT_BASE + 24 * k + 16, xs[k] ^ ys[k], "random XOR");
    end
    end_test();
  endtask

  initial begin
    core_rst_n   = 1'b1;
    rng_state    = 32'h70b4;
    tests_passed = 0;
    tests_failed = 0;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = fill_value(i);
    @(posedge por_n);
    arith_logic_test();
    word_load_test();
    control_flow_test();
    lui_imm_test();
    random_operand_test();
    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all tests finished");
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/clock_gen.sv */
// ====================
// Testbench clock and power-on reset
// ====================

`timescale 1ns/100ps
`default_nettype none

module clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 10,
  parameter int DRIVE_DELAY  = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset low for the first cycles, released just after an edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #DRIVE_DELAY rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* rtl/riscv_core.sv */
// ====================
// RV64 multicycle core
// Control unit and dataflow on a plain memory port
// ====================

`timescale 1ns/100ps
`default_nettype none
`include "riscv_config.svh"

module riscv_core (
  input  wire logic             clk_i,
  input  wire logic             rst_n_i,
  input  wire logic [`XLEN-1:0] mem_rdata_i,
  output logic [`XLEN-1:0]      mem_addr_o,
  output logic [`XLEN-1:0]      mem_wdata_o,
  output logic                  mem_we_o,
  output logic                  halted_o
);

  // Strobes and decoded fields between the two halves
  dataflow_ctrl_if ctrl_bus ();

  control_unit u_control (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .ctrl_if  (ctrl_bus.ctrl),
    .mem_we_o (mem_we_o),
    .halted_o (halted_o)
  );

  dataflow u_dataflow (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ctrl_if     (ctrl_bus.data),
    .mem_rdata_i (mem_rdata_i),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o)
  );

endmodule

`default_nettype wire

/* rtl/control_unit.sv */
// ====================
// Multicycle control unit
// Decodes the instruction and steps the dataflow
// ====================

`timescale 1ns/100ps
`default_nettype none

module control_unit import riscv_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     rst_n_i,
  dataflow_ctrl_if.ctrl ctrl_if,
  output logic          mem_we_o,
  output logic          halted_o
);

  typedef enum logic [2:0] {
    FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK, HALT
  } state_e;

  state_e     state_q;
  state_e     state_d;
  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       opcode_ok;
  logic       rd_nz;
  logic       cond;
  logic       taken;

  assign opcode = opcode_e'(ctrl_if.insn[6:0]);
  assign funct3 = ctrl_if.insn[14:12];
  assign funct7 = ctrl_if.insn[31:25];
  assign rd_nz  = |ctrl_if.insn[11:7];

  always_comb begin
    case (opcode)
      OPC_OP, OPC_OP_IMM, OPC_OP_32, OPC_LOAD, OPC_STORE,
      OPC_BRANCH, OPC_JAL, OPC_LUI, OPC_SYSTEM: opcode_ok = 1'b1;
      default: opcode_ok = 1'b0;
    endcase
  end

  // ALU function from funct3, funct7 bit 5 selects SUB on register ops
  always_comb begin
    ctrl_if.alu_op = ALU_ADD;
    if (opcode == OPC_BRANCH) begin
      ctrl_if.alu_op = ALU_SUB;
    end else if (opcode inside {OPC_OP, OPC_OP_IMM, OPC_OP_32}) begin
      case (funct3)
        3'b000: ctrl_if.alu_op = (opcode != OPC_OP_IMM && funct7[5]) ? ALU_SUB : ALU_ADD;
        3'b010: ctrl_if.alu_op = ALU_SLT;
        3'b011: ctrl_if.alu_op = ALU_SLTU;
        3'b100: ctrl_if.alu_op = ALU_XOR;
        3'b110: ctrl_if.alu_op = ALU_OR;
        3'b111: ctrl_if.alu_op = ALU_AND;
        default: ctrl_if.alu_op = ALU_ADD;
      endcase
    end
  end

  always_comb begin
    case (opcode)
      OPC_STORE:  ctrl_if.imm_fmt = IMM_S;
      OPC_BRANCH: ctrl_if.imm_fmt = IMM_B;
      OPC_JAL:    ctrl_if.imm_fmt = IMM_J;
      OPC_LUI:    ctrl_if.imm_fmt = IMM_U;
      default:    ctrl_if.imm_fmt = IMM_I;
    endcase
  end

  assign ctrl_if.word_mode = (opcode == OPC_OP_32);
  assign ctrl_if.mem_ext   = (funct3 == 3'b011) ? EXT_DOUBLE : EXT_WORD;

  // Branch condition, funct3 bit 0 inverts it
  always_comb begin
    case (funct3[2:1])
      2'b00:   cond = ctrl_if.eq;
      2'b10:   cond = ctrl_if.lt;
      2'b11:   cond = ctrl_if.ltu;
      default: cond = 1'b0;
    endcase
  end
  assign taken = cond ^ funct3[0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= FETCH;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH:     state_d = DECODE;
      DECODE:    state_d = (opcode_ok && opcode != OPC_SYSTEM) ? EXECUTE : HALT;
      EXECUTE:   state_d = (opcode inside {OPC_LOAD, OPC_STORE}) ? MEMORY : WRITEBACK;
      MEMORY:    state_d = (opcode == OPC_LOAD) ? WRITEBACK : FETCH;
      WRITEBACK: state_d = FETCH;
      default:   state_d = HALT;
    endcase
  end

  always_comb begin
    ctrl_if.load_ir       = 1'b0;
    ctrl_if.load_ops      = 1'b0;
    ctrl_if.load_imm      = 1'b0;
    ctrl_if.load_alu      = 1'b0;
    ctrl_if.load_mem_data = 1'b0;
    ctrl_if.load_pc       = 1'b0;
    ctrl_if.load_regfile  = 1'b0;
    ctrl_if.load_flags    = 1'b0;
    ctrl_if.sel_alu_a     = 1'b0;
    ctrl_if.sel_alu_b     = 1'b0;
    ctrl_if.sel_addr      = 1'b0;
    ctrl_if.sel_pc_branch = 1'b0;
    ctrl_if.sel_wb        = WB_ALU;
    mem_we_o              = 1'b0;
    case (state_q)
      FETCH: ctrl_if.load_ir = 1'b1;
      DECODE: begin
        ctrl_if.load_ops = 1'b1;
        ctrl_if.load_imm = 1'b1;
      end
      EXECUTE: begin
        ctrl_if.sel_alu_a  = (opcode == OPC_JAL);
        ctrl_if.sel_alu_b  = !(opcode inside {OPC_OP, OPC_OP_32, OPC_BRANCH});
        ctrl_if.load_alu   = !(opcode inside {OPC_BRANCH, OPC_LUI});
        ctrl_if.load_flags = (opcode == OPC_BRANCH);
      end
      MEMORY: begin
        ctrl_if.sel_addr      = 1'b1;
        ctrl_if.load_mem_data = (opcode == OPC_LOAD);
        // A store finishes here
        mem_we_o              = (opcode == OPC_STORE);
        ctrl_if.load_pc       = (opcode == OPC_STORE);
      end
      WRITEBACK: begin
        ctrl_if.load_pc       = 1'b1;
        ctrl_if.sel_pc_branch = (opcode == OPC_JAL) || (opcode == OPC_BRANCH && taken);
        ctrl_if.load_regfile  = rd_nz && (opcode != OPC_BRANCH);
        case (opcode)
          OPC_LOAD: ctrl_if.sel_wb = WB_MEM;
          OPC_LUI:  ctrl_if.sel_wb = WB_IMM;
          OPC_JAL:  ctrl_if.sel_wb = WB_PC4;
          default:  ctrl_if.sel_wb = WB_ALU;
        endcase
      end
      default: ;
    endcase
  end

  // EBREAK shows halt already in its decode cycle
  assign halted_o = (state_q == HALT) || (state_q == DECODE && opcode == OPC_SYSTEM);

  a_we_excl : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(mem_we_o && ctrl_if.load_regfile))
    else $error("memory write and register write in the same cycle");

  a_halt_quiet : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_q == HALT) |-> !(mem_we_o || ctrl_if.load_ir || ctrl_if.load_ops ||
      ctrl_if.load_imm || ctrl_if.load_alu || ctrl_if.load_mem_data ||
      ctrl_if.load_pc || ctrl_if.load_regfile || ctrl_if.load_flags))
    else $error("strobe active while halted");

endmodule

`default_nettype wire

/* rtl/dataflow.sv */
// ====================
// RV64 dataflow
// Datapath registers, PC, register file and ALU
// ====================

`timescale 1ns/100ps
`default_nettype none
`include "riscv_config.svh"

module dataflow import riscv_pkg::*; (
  input  wire logic             clk_i,
  input  wire logic             rst_n_i,
  dataflow_ctrl_if.data         ctrl_if,
  input  wire logic [`XLEN-1:0] mem_rdata_i,
  output logic [`XLEN-1:0]      mem_addr_o,
  output logic [`XLEN-1:0]      mem_wdata_o
);

  logic [31:0]      ir_q;
  logic [`XLEN-1:0] rs1_q;
  logic [`XLEN-1:0] rs2_q;
  logic [`XLEN-1:0] imm_q;
  logic [`XLEN-1:0] alu_q;
  logic [`XLEN-1:0] mem_data_q;
  logic [`XLEN-1:0] pc_q;
  // Flags kept as {ltu, lt, eq}
  logic [2:0]       flags_q;

  logic [31:0]      fetch_word;
  logic [31:0]      load_word;
  logic [`XLEN-1:0] rs1_rd;
  logic [`XLEN-1:0] rs2_rd;
  logic [`XLEN-1:0] imm_val;
  logic [`XLEN-1:0] alu_a;
  logic [`XLEN-1:0] alu_b;
  logic [`XLEN-1:0] alu_res;
  logic [`XLEN-1:0] load_data;
  logic [`XLEN-1:0] wb_data;
  logic [`XLEN-1:0] pc_plus4;
  logic [`XLEN-1:0] pc_target;
  logic [`XLEN-1:0] pc_next;
  logic             alu_eq;
  logic             alu_lt;
  logic             alu_ltu;

  // Memory is doubleword wide, PC bit 2 picks the instruction half
  assign fetch_word = pc_q[2] ? mem_rdata_i[`XLEN-1:32] : mem_rdata_i[31:0];

  always_ff @(posedge clk_i) begin
    if (ctrl_if.load_ir) ir_q <= fetch_word;
    if (ctrl_if.load_ops) begin
      rs1_q <= rs1_rd;
      rs2_q <= rs2_rd;
    end
    if (ctrl_if.load_imm) imm_q <= imm_val;
    if (ctrl_if.load_alu) alu_q <= alu_res;
    if (ctrl_if.load_mem_data) mem_data_q <= mem_rdata_i;
    if (ctrl_if.load_flags) flags_q <= {alu_ltu, alu_lt, alu_eq};
  end

  // Program counter
  assign pc_plus4  = pc_q + `XLEN'd4;
  assign pc_target = pc_q + imm_q;
  assign pc_next   = ctrl_if.sel_pc_branch ? pc_target : pc_plus4;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pc_q <= `RESET_PC;
    end else if (ctrl_if.load_pc) begin
      pc_q <= pc_next;
    end
  end

  assign alu_a = ctrl_if.sel_alu_a ? pc_q : rs1_q;
  assign alu_b = ctrl_if.sel_alu_b ? imm_q : rs2_q;

  // Word loads take the half given by address bit 2
  assign load_word = alu_q[2] ? mem_data_q[`XLEN-1:32] : mem_data_q[31:0];
  assign load_data = (ctrl_if.mem_ext == EXT_WORD) ?
                     {{(`XLEN-32){load_word[31]}}, load_word} : mem_data_q;

  always_comb begin
    case (ctrl_if.sel_wb)
      WB_MEM:  wb_data = load_data;
      WB_IMM:  wb_data = imm_q;
      WB_ALU:  wb_data = alu_q;
      default: wb_data = pc_plus4;
    endcase
  end

  imm_gen u_imm_gen (
    .insn_i    (ir_q),
    .imm_fmt_i (ctrl_if.imm_fmt),
    .imm_o     (imm_val)
  );

  alu u_alu (
    .a_i         (alu_a),
    .b_i         (alu_b),
    .op_i        (ctrl_if.alu_op),
    .word_mode_i (ctrl_if.word_mode),
    .result_o    (alu_res),
    .eq_o        (alu_eq),
    .lt_o        (alu_lt),
    .ltu_o       (alu_ltu)
  );

  regfile u_regfile (
    .clk_i      (clk_i),
    .we_i       (ctrl_if.load_regfile),
    .rd_addr_i  (ir_q[11:7]),
    .rs1_addr_i (ir_q[19:15]),
    .rs2_addr_i (ir_q[24:20]),
    .rd_data_i  (wb_data),
    .rs1_data_o (rs1_rd),
    .rs2_data_o (rs2_rd)
  );

  assign ctrl_if.insn = ir_q;
  assign ctrl_if.eq   = flags_q[0];
  assign ctrl_if.lt   = flags_q[1];
  assign ctrl_if.ltu  = flags_q[2];

  assign mem_addr_o  = ctrl_if.sel_addr ? alu_q : pc_q;
  assign mem_wdata_o = rs2_q;

  a_pc_aligned : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pc_q[1:0] == 2'b00)
    else $error("PC lost 4-byte alignment");

endmodule

`default_nettype wire

/* rtl/regfile.sv */
// ====================
// Integer register file
// Two read ports, one write port, x0 reads zero
// ====================

`timescale 1ns/100ps
`default_nettype none
`include "riscv_config.svh"

module regfile (
  input  wire logic                          clk_i,
  input  wire logic                          we_i,
  input  wire logic [$clog2(`REG_COUNT)-1:0] rd_addr_i,
  input  wire logic [$clog2(`REG_COUNT)-1:0] rs1_addr_i,
  input  wire logic [$clog2(`REG_COUNT)-1:0] rs2_addr_i,
  input  wire logic [`XLEN-1:0]              rd_data_i,
  output logic [`XLEN-1:0]                   rs1_data_o,
  output logic [`XLEN-1:0]                   rs2_data_o
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      regs[rd_addr_i] <= rd_data_i;
    end
  end

  // Register 0 is hardwired to zero on read
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

  // The control unit drops writes to x0 before they get here
  a_no_x0_write : assert property (@(posedge clk_i) we_i |-> (rd_addr_i != '0))
    else $error("regfile write to x0");

endmodule

`default_nettype wire

/* rtl/alu.sv */
// ====================
// Integer ALU
// Arithmetic, logic, word mode and compare flags
// ====================

`timescale 1ns/100ps
`default_nettype none
`include "riscv_config.svh"

module alu import riscv_pkg::*; (
  input  wire logic [`XLEN-1:0] a_i,
  input  wire logic [`XLEN-1:0] b_i,
  input  wire alu_op_e          op_i,
  input  wire logic             word_mode_i,
  output logic [`XLEN-1:0]      result_o,
  output logic                  eq_o,
  output logic                  lt_o,
  output logic                  ltu_o
);

  logic [`XLEN-1:0] raw;
  logic             lt_s;
  logic             lt_u;

  // Comparisons on the full operands
  assign lt_s = $signed(a_i) < $signed(b_i);
  assign lt_u = a_i < b_i;

  always_comb begin
    case (op_i)
      ALU_ADD:  raw = a_i + b_i;
      ALU_SUB:  raw = a_i - b_i;
      ALU_AND:  raw = a_i & b_i;
      ALU_OR:   raw = a_i | b_i;
      ALU_XOR:  raw = a_i ^ b_i;
      ALU_SLT:  raw = {{(`XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: raw = {{(`XLEN-1){1'b0}}, lt_u};
      default:  raw = '0;
    endcase
  end

  // Word mode keeps the low half, sign-extended
  assign result_o = word_mode_i ? {{(`XLEN-32){raw[31]}}, raw[31:0]} : raw;

  assign eq_o  = (a_i == b_i);
  assign lt_o  = lt_s;
  assign ltu_o = lt_u;

endmodule

`default_nettype wire

/* rtl/imm_gen.sv */
// ====================
// Immediate generator
// Sign-extends the I, S, B, J and U immediates
// ====================

`timescale 1ns/100ps
`default_nettype none
`include "riscv_config.svh"

module imm_gen import riscv_pkg::*; (
  input  wire logic [31:0]      insn_i,
  input  wire imm_fmt_e         imm_fmt_i,
  output logic [`XLEN-1:0]      imm_o
);

  logic sign;

  // Sign bit is always instruction bit 31
  assign sign = insn_i[31];

  always_comb begin
    case (imm_fmt_i)
      IMM_S: begin
        imm_o = {{(`XLEN-12){sign}}, insn_i[31:25], insn_i[11:7]};
      end
      IMM_B: begin
        imm_o = {{(`XLEN-13){sign}}, insn_i[31], insn_i[7], insn_i[30:25],
                 insn_i[11:8], 1'b0};
      end
      IMM_J: begin
        imm_o = {{(`XLEN-21){sign}}, insn_i[31], insn_i[19:12], insn_i[20],
                 insn_i[30:21], 1'b0};
      end
      IMM_U: begin
        // Upper 20 bits, low 12 zero
        imm_o = {{(`XLEN-32){sign}}, insn_i[31:12], 12'b0};
      end
      default: begin
        imm_o = {{(`XLEN-12){sign}}, insn_i[31:20]};
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/dataflow_ctrl_if.sv */
// ====================
// Control to dataflow bus
// Load strobes, selects, decoded fields and flags
// ====================

`timescale 1ns/100ps
`default_nettype none

interface dataflow_ctrl_if import riscv_pkg::*; ();

  // Register load strobes
  logic load_ir, load_ops, load_imm, load_alu;
  logic load_mem_data, load_pc, load_regfile, load_flags;

  logic     sel_alu_a;
  logic     sel_alu_b;
  logic     sel_addr;
  logic     sel_pc_branch;
  wb_sel_e  sel_wb;
  alu_op_e  alu_op;
  logic     word_mode;
  mem_ext_e mem_ext;
  imm_fmt_e imm_fmt;

  // Returned by the dataflow
  logic [31:0] insn;
  logic        eq, lt, ltu;

  modport ctrl (
    output load_ir, load_ops, load_imm, load_alu, load_mem_data, load_pc, load_regfile,
    output load_flags, sel_alu_a, sel_alu_b, sel_addr, sel_pc_branch, sel_wb,
    output alu_op, word_mode, mem_ext, imm_fmt,
    input  insn, eq, lt, ltu
  );

  modport data (
    input  load_ir, load_ops, load_imm, load_alu, load_mem_data, load_pc, load_regfile,
    input  load_flags, sel_alu_a, sel_alu_b, sel_addr, sel_pc_branch, sel_wb,
    input  alu_op, word_mode, mem_ext, imm_fmt,
    output insn, eq, lt, ltu
  );

endinterface

`default_nettype wire

/* rtl/riscv_pkg.sv */
// ====================
// RV64 core types
// Opcodes, ALU functions and datapath selects
// ====================

`default_nettype none

package riscv_pkg;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP_32  = 7'b0111011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_LUI    = 7'b0110111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU
  } alu_op_e;

  // Writeback source, same order as the 4-to-1 rd mux
  typedef enum logic [1:0] {
    WB_MEM, WB_IMM, WB_ALU, WB_PC4
  } wb_sel_e;

  typedef enum logic {
    EXT_DOUBLE, EXT_WORD
  } mem_ext_e;

  // Immediate formats
  typedef enum logic [2:0] {
    IMM_I, IMM_S, IMM_B, IMM_J, IMM_U
  } imm_fmt_e;

endpackage

`default_nettype wire

/* rtl/riscv_config.svh */
// ====================
// Core configuration
// Data width, register count and reset PC
// ====================

`ifndef RISCV_CONFIG_SVH
`define RISCV_CONFIG_SVH

// Data and address width
`define XLEN 64
`define REG_COUNT 32
`define RESET_PC 64'h0

`endif
